/* retire_pkg.sv */
////////////////////////////////////////////////////////////
// Retire datapath widths and vector types
// Execution unit and instruction operation encodings
////////////////////////////////////////////////////////////
package retire_pkg;

    localparam int XLEN      = 32;          // Data, address and pc width
    localparam int TAG_W     = 3;           // Instruction and retire tag width
    localparam int BYTE_EN_W = XLEN / 8;    // One enable per memory byte

    typedef logic [XLEN-1:0]      xlen_t;
    typedef logic [TAG_W-1:0]     tag_t;
    typedef logic [BYTE_EN_W-1:0] byte_en_t;

    // Unit that executed the operation, top 3 bits of iop_e
    typedef enum logic [2:0] {
        ADDER_UNIT   = 3'b000,
        LOGICAL_UNIT = 3'b001,
        SHIFTER_UNIT = 3'b010,
        BRANCH_UNIT  = 3'b011,
        BYPASS_UNIT  = 3'b100,
        MEMORY_UNIT  = 3'b101,
        PRIV_UNIT    = 3'b110
    } exec_unit_e;

    typedef enum logic [5:0] {
        ADD    = 6'b000_000, SUB    = 6'b000_001,
        XOR    = 6'b001_000, OR     = 6'b001_001, AND   = 6'b001_010,
        SLL    = 6'b010_000, SRL    = 6'b010_001,
        BEQ    = 6'b011_000, BNE    = 6'b011_001,
        JAL    = 6'b011_100, JALR   = 6'b011_101,
        NOP    = 6'b100_000, LUI    = 6'b100_001,
        LB     = 6'b101_000, LBU    = 6'b101_001, LH    = 6'b101_010,
        LHU    = 6'b101_011, LW     = 6'b101_100,
        SB     = 6'b101_101, SH     = 6'b101_110, SW    = 6'b101_111,
        ECALL  = 6'b110_000, EBREAK = 6'b110_001, MRET  = 6'b110_010
    } iop_e;

    // Execution unit field of an operation
    function automatic exec_unit_e unit_of(iop_e op);
        return exec_unit_e'(op[5:3]);
    endfunction

endpackage

/* priv_pkg.sv */
////////////////////////////////////////////////////////////
// Machine mode trap definitions
// Exception codes, mcause values, trap and reset addresses
////////////////////////////////////////////////////////////
package priv_pkg;

    import retire_pkg::*;

    // Synchronous exception causes, values as in mcause
    typedef enum logic [3:0] {
        NE                  = 4'd0,     // No exception
        ILLEGAL_INSTRUCTION = 4'd2,
        BREAKPOINT          = 4'd3,
        ECALL_FROM_MMODE    = 4'd11
    } exc_code_e;

    typedef logic [XLEN-1:0] mcause_t;

    // Interrupt flag in the top bit, code 11 for machine external
    localparam mcause_t MCAUSE_EXT_IRQ = {1'b1, 27'd0, 4'd11};

    localparam xlen_t TRAP_VECTOR = 32'h0000_0100;  // Common handler entry
    localparam xlen_t MEPC_RESET  = 32'h0000_0000;

    // Major opcode shared by ECALL, EBREAK and MRET
    localparam logic [6:0] OPCODE_SYSTEM = 7'b111_0011;

endpackage

/* commit_if.sv */
////////////////////////////////////////////////////////////
// Trap events from the retire stage to the trap unit
////////////////////////////////////////////////////////////
interface commit_if;

    import retire_pkg::*;
    import priv_pkg::*;

    // All single cycle levels, valid with the retiring instruction
    logic      raise_exception;     // Synchronous exception taken
    exc_code_e exception_code;      // Cause, NE when no exception
    logic      machine_return;      // MRET retired
    logic      interrupt_ack;       // Pending interrupt taken here
    xlen_t     epc;                 // pc of the retiring instruction

    modport source (
        output raise_exception,
        output exception_code,
        output machine_return,
        output interrupt_ack,
        output epc
    );

    modport sink (
        input raise_exception,
        input exception_code,
        input machine_return,
        input interrupt_ack,
        input epc
    );

endinterface

/* load_aligner.sv */
////////////////////////////////////////////////////////////
// Load formatting: byte and halfword extraction from the
// memory word with sign or zero extension
////////////////////////////////////////////////////////////
module load_aligner (
    input  retire_pkg::iop_e  operation_i,
    input  logic [1:0]        addr_low_i,      // Byte offset inside the word
    input  retire_pkg::xlen_t mem_data_i,      // Whole aligned word from memory
    output retire_pkg::xlen_t load_data_o
);

    import retire_pkg::*;

    logic [7:0]  byte_sel;
    logic [15:0] half_sel;
    logic        is_load_op;
    logic        signed_op;

    // Lane select, little endian
    assign byte_sel = mem_data_i[{addr_low_i, 3'b000} +: 8];
    assign half_sel = mem_data_i[{addr_low_i[1], 4'b0000} +: 16];   // Bit 0 ignored

    assign is_load_op = (unit_of(operation_i) == MEMORY_UNIT);
    assign signed_op  = (operation_i == LB) || (operation_i == LH);

    always_comb begin
        load_data_o = mem_data_i;       // LW, stores and other units pass through
        if (is_load_op) begin
            case (operation_i)
                LB, LBU: begin
                    load_data_o = {{24{signed_op & byte_sel[7]}}, byte_sel};
                end
                LH, LHU: begin
                    load_data_o = {{16{signed_op & half_sel[15]}}, half_sel};
                end
                default: begin
                    load_data_o = mem_data_i;
                end
            endcase
        end
    end

endmodule

/* retire_stage.sv */
////////////////////////////////////////////////////////////
// Retire stage: tag compare and kill, retire tag counter,
// register, memory and jump gating, trap event decode
////////////////////////////////////////////////////////////
module retire_stage (
    input  logic                 clk,
    input  logic                 reset,
    input  retire_pkg::xlen_t    instruction_i,
    input  retire_pkg::xlen_t    pc_i,
    input  retire_pkg::xlen_t    result0_i,             // Write-back or store data
    input  retire_pkg::xlen_t    result1_i,             // Memory address or jump target
    input  retire_pkg::tag_t     tag_i,
    input  retire_pkg::byte_en_t mem_write_enable_i,
    input  logic                 write_enable_i,
    input  logic                 jump_i,                // Taken branch or jump from execute
    input  retire_pkg::iop_e     operation_i,
    input  logic                 exception_i,           // Decode flagged illegal
    input  logic                 interrupt_pending_i,
    input  retire_pkg::xlen_t    load_data_i,           // Formatted load data
    output logic                 regbank_write_enable_o,
    output retire_pkg::xlen_t    regbank_data_o,
    output logic                 jump_o,
    output retire_pkg::xlen_t    jump_target_o,
    output logic                 killed_o,
    output retire_pkg::byte_en_t mem_write_enable_o,
    output retire_pkg::xlen_t    mem_write_address_o,
    output retire_pkg::xlen_t    mem_data_o,
    output retire_pkg::tag_t     current_tag_o,
    commit_if.source             commit
);

    import retire_pkg::*;
    import priv_pkg::*;

    tag_t       curr_tag;       // Tag of the path being retired
    logic       jump_r;         // Jump retired last cycle
    logic       killed;
    logic       store_live;
    exec_unit_e unit;

    // Trap events before they go onto the commit bus
    logic       raise_exc;
    exc_code_e  exc_code;
    logic       mret;
    logic       irq_ack;

    assign unit          = unit_of(operation_i);
    assign current_tag_o = curr_tag;

    ////////////////////////////////////////////////////////////
    // Kill and retire tag
    ////////////////////////////////////////////////////////////

    // Stale path, or the slot right behind a jump
    assign killed   = (tag_i != curr_tag) || jump_r;
    assign killed_o = killed;

    always_ff @(posedge clk) begin
        if (reset) begin
            curr_tag <= '0;
            jump_r   <= 1'b0;
        end else begin
            jump_r <= jump_o;
            // Every redirect opens a new path
            if (jump_o || raise_exc || mret || irq_ack) begin
                curr_tag <= curr_tag + tag_t'(1);
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Register, jump and memory outputs
    ////////////////////////////////////////////////////////////

    assign regbank_write_enable_o = write_enable_i && !killed;
    assign regbank_data_o         = (unit == MEMORY_UNIT) ? load_data_i : result0_i;

    assign jump_o        = jump_i && !killed;
    assign jump_target_o = jump_o ? result1_i : '0;

    assign store_live          = (mem_write_enable_i != '0) && !killed;
    assign mem_write_enable_o  = store_live ? mem_write_enable_i : '0;
    assign mem_write_address_o = store_live ? result1_i : '0;
    assign mem_data_o          = store_live ? result0_i : '0;

    ////////////////////////////////////////////////////////////
    // Trap events
    ////////////////////////////////////////////////////////////

    always_comb begin
        raise_exc = 1'b0;
        exc_code  = NE;
        mret      = 1'b0;
        irq_ack   = 1'b0;
        if (!killed) begin
            if (exception_i) begin                  // Highest priority
                raise_exc = 1'b1;
                exc_code  = ILLEGAL_INSTRUCTION;
            end else if (operation_i == ECALL) begin
                raise_exc = 1'b1;
                exc_code  = ECALL_FROM_MMODE;
            end else if (operation_i == EBREAK) begin
                raise_exc = 1'b1;
                exc_code  = BREAKPOINT;
            end else if (operation_i == MRET) begin
                mret = 1'b1;
            end else if (interrupt_pending_i) begin
                irq_ack = 1'b1;                     // Taken on a live slot only
            end
        end
    end

    assign commit.raise_exception = raise_exc;
    assign commit.exception_code  = exc_code;
    assign commit.machine_return  = mret;
    assign commit.interrupt_ack   = irq_ack;
    assign commit.epc             = pc_i;

    // Trap unit relies on a single event per cycle
    a_single_event: assert property (@(posedge clk) disable iff (reset)
        $onehot0({raise_exc, mret, irq_ack}))
        else $error("more than one trap event in one cycle");

    a_killed_quiet: assert property (@(posedge clk) disable iff (reset)
        killed |-> !regbank_write_enable_o && (mem_write_enable_o == '0) && !jump_o)
        else $error("killed instruction changed architectural state");

    // Decode and retire must agree on system instructions
    a_system_opcode: assert property (@(posedge clk) disable iff (reset)
        (!killed && unit == PRIV_UNIT) |-> (instruction_i[6:0] == OPCODE_SYSTEM))
        else $error("system operation without SYSTEM opcode");

endmodule

/* trap_unit.sv */
////////////////////////////////////////////////////////////
// Machine mode trap state: mepc and mcause, trap redirect
////////////////////////////////////////////////////////////
module trap_unit (
    input  logic              clk,
    input  logic              reset,
    commit_if.sink            commit,
    output logic              trap_redirect_o,
    output retire_pkg::xlen_t trap_target_o,
    output retire_pkg::xlen_t mepc_o,
    output priv_pkg::mcause_t mcause_o
);

    import retire_pkg::*;
    import priv_pkg::*;

    xlen_t   mepc_q;
    mcause_t mcause_q;
    logic    enter_trap;    // Exception or interrupt, both go to the vector

    assign enter_trap = commit.raise_exception || commit.interrupt_ack;

    always_ff @(posedge clk) begin
        if (reset) begin
            mepc_q   <= MEPC_RESET;
            mcause_q <= '0;
        end else if (commit.raise_exception) begin
            mepc_q   <= commit.epc;                          // Faulting instruction
            mcause_q <= mcause_t'(commit.exception_code);
        end else if (commit.interrupt_ack) begin
            mepc_q   <= commit.epc + xlen_t'(4);             // Instruction itself completed
            mcause_q <= MCAUSE_EXT_IRQ;
        end
    end

    assign trap_redirect_o = enter_trap || commit.machine_return;

    always_comb begin
        if (enter_trap) begin
            trap_target_o = TRAP_VECTOR;
        end else if (commit.machine_return) begin
            trap_target_o = mepc_q;                          // Value before this edge
        end else begin
            trap_target_o = '0;
        end
    end

    assign mepc_o   = mepc_q;
    assign mcause_o = mcause_q;

    a_redirect_one_event: assert property (@(posedge clk) disable iff (reset)
        trap_redirect_o |->
            $onehot({commit.raise_exception, commit.interrupt_ack, commit.machine_return}))
        else $error("trap redirect without exactly one commit event");

endmodule

/* retire_top.sv */
////////////////////////////////////////////////////////////
// Retire top level: retire stage, load aligner, trap unit
////////////////////////////////////////////////////////////
module retire_top (
    input  logic                 clk,
    input  logic                 reset,
    input  retire_pkg::xlen_t    instruction_i,
    input  retire_pkg::xlen_t    pc_i,
    input  retire_pkg::xlen_t    result0_i,
    input  retire_pkg::xlen_t    result1_i,
    input  retire_pkg::tag_t     tag_i,
    input  retire_pkg::byte_en_t mem_write_enable_i,
    input  logic                 write_enable_i,
    input  logic                 jump_i,
    input  retire_pkg::iop_e     operation_i,
    input  logic                 exception_i,
    input  logic                 interrupt_pending_i,
    input  retire_pkg::xlen_t    mem_data_i,            // Load word, same cycle
    output logic                 regbank_write_enable_o,
    output retire_pkg::xlen_t    regbank_data_o,
    output logic                 jump_o,
    output retire_pkg::xlen_t    jump_target_o,
    output logic                 killed_o,
    output retire_pkg::byte_en_t mem_write_enable_o,
    output retire_pkg::xlen_t    mem_write_address_o,
    output retire_pkg::xlen_t    mem_data_o,
    output retire_pkg::tag_t     current_tag_o,
    output logic                 trap_redirect_o,
    output retire_pkg::xlen_t    trap_target_o,
    output retire_pkg::xlen_t    mepc_o,
    output priv_pkg::mcause_t    mcause_o
);

    import retire_pkg::*;

    xlen_t load_data;       // Aligner to write-back mux

    commit_if commit_bus ();

    load_aligner load_aligner_i (
        .operation_i (operation_i),
        .addr_low_i  (result1_i[1:0]),      // Address travels on result1
        .mem_data_i  (mem_data_i),
        .load_data_o (load_data)
    );

    retire_stage retire_stage_i (
        .clk                    (clk),
        .reset                  (reset),
        .instruction_i          (instruction_i),
        .pc_i                   (pc_i),
        .result0_i              (result0_i),
        .result1_i              (result1_i),
        .tag_i                  (tag_i),
        .mem_write_enable_i     (mem_write_enable_i),
        .write_enable_i         (write_enable_i),
        .jump_i                 (jump_i),
        .operation_i            (operation_i),
        .exception_i            (exception_i),
        .interrupt_pending_i    (interrupt_pending_i),
        .load_data_i            (load_data),
        .regbank_write_enable_o (regbank_write_enable_o),
        .regbank_data_o         (regbank_data_o),
        .jump_o                 (jump_o),
        .jump_target_o          (jump_target_o),
        .killed_o               (killed_o),
        .mem_write_enable_o     (mem_write_enable_o),
        .mem_write_address_o    (mem_write_address_o),
        .mem_data_o             (mem_data_o),
        .current_tag_o          (current_tag_o),
        .commit                 (commit_bus.source)
    );

    trap_unit trap_unit_i (
        .clk             (clk),
        .reset           (reset),
        .commit          (commit_bus.sink),
        .trap_redirect_o (trap_redirect_o),
        .trap_target_o   (trap_target_o),
        .mepc_o          (mepc_o),
        .mcause_o        (mcause_o)
    );

endmodule

/* tb_retire_top.sv */
////////////////////////////////////////////////////////////
// Testbench for the retire top level
// Stimulus and expected value table applied once per cycle
////////////////////////////////////////////////////////////
module tb_retire_top;

    timeunit 1ns;
    timeprecision 100ps;

    import retire_pkg::*;
    import priv_pkg::*;

    localparam int    RESET_CYCLES  = 16;
    localparam int    RESET_TIMEOUT = 40;             // Cycles allowed for reset release
    localparam xlen_t LOAD_WORD     = 32'hF182_7E93;  // Bytes F1 82 7E 93, memory word

    // One table row, inputs first, then expected outputs
    typedef struct {
        iop_e     op;
        xlen_t    instr;
        xlen_t    pc;
        xlen_t    r0;
        xlen_t    r1;
        tag_t     tag;
        byte_en_t be;
        logic     we;
        logic     jmp;
        logic     exc;
        logic     irq;
        logic     rnd;          // result0 comes from $urandom
        logic     e_we;
        xlen_t    e_data;
        logic     e_jmp;
        xlen_t    e_jtgt;
        byte_en_t e_be;
        xlen_t    e_addr;
        xlen_t    e_mdata;      // Store data on the memory port
        logic     e_kill;
        tag_t     e_tag;
        logic     e_redir;
        xlen_t    e_ttgt;
        mcause_t  e_mcause;     // After the row's closing edge
        xlen_t    e_mepc;
    } row_t;

    logic     clk;
    logic     reset;
    xlen_t    instruction_i, pc_i, result0_i, result1_i, mem_data_i;
    tag_t     tag_i;
    byte_en_t mem_write_enable_i;
    logic     write_enable_i, jump_i, exception_i, interrupt_pending_i;
    iop_e     operation_i;
    logic     regbank_write_enable_o, jump_o, killed_o, trap_redirect_o;
    xlen_t    regbank_data_o, jump_target_o, mem_write_address_o, mem_data_o;
    xlen_t    trap_target_o, mepc_o;
    byte_en_t mem_write_enable_o;
    tag_t     current_tag_o;
    mcause_t  mcause_o;

    row_t    rows[$];
    mcause_t trap_mcause;       // Trap state expected once a row has retired
    xlen_t   trap_mepc;

    retire_top retire_top_i (.*);

    always #5 clk = ~clk;       // 10 ns period

    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;
    end

    ////////////////////////////////////////////////////////////
    // Row builders
    ////////////////////////////////////////////////////////////

    function automatic row_t base_row(iop_e op, tag_t tag, tag_t e_tag, logic e_kill);
        row_t r;
        r.op = op;
        case (op)                                   // SYSTEM encodings for privileged ops
            ECALL:   r.instr = 32'h0000_0073;
            EBREAK:  r.instr = 32'h0010_0073;
            MRET:    r.instr = 32'h3020_0073;
            default: r.instr = 32'h0020_81B3;       // add x3, x1, x2
        endcase
        r.pc      = 32'h0000_0010;
        r.r0      = '0;
        r.r1      = '0;
        r.tag     = tag;
        r.be      = '0;
        r.we      = 1'b0;
        r.jmp     = 1'b0;
        r.exc     = 1'b0;
        r.irq     = 1'b0;
        r.rnd     = 1'b0;
        r.e_we    = 1'b0;
        r.e_data  = '0;
        r.e_jmp   = 1'b0;
        r.e_jtgt  = '0;
        r.e_be    = '0;
        r.e_addr  = '0;
        r.e_mdata = '0;
        r.e_kill  = e_kill;
        r.e_tag   = e_tag;
        r.e_redir = 1'b0;
        r.e_ttgt  = '0;
        return r;
    endfunction

    function automatic row_t alu_row(tag_t tag, tag_t e_tag, logic e_kill, xlen_t r0);
        row_t r;
        r = base_row(ADD, tag, e_tag, e_kill);
        r.we     = 1'b1;
        r.r0     = r0;
        r.rnd    = e_kill;      // Nothing written, value is free
        r.e_we   = !e_kill;
        r.e_data = r0;
        return r;
    endfunction

    // Load from a word address plus byte offset, live with tag 0
    function automatic row_t load_row(iop_e op, logic [1:0] off, xlen_t e_data);
        row_t r;
        r = base_row(op, 3'd0, 3'd0, 1'b0);
        r.we     = 1'b1;
        r.r1     = 32'h2000_0000 + xlen_t'(off);
        r.rnd    = 1'b1;
        r.e_we   = 1'b1;
        r.e_data = e_data;
        return r;
    endfunction

    function automatic row_t exc_row(iop_e op, tag_t tag, xlen_t pc);
        row_t r;
        r = base_row(op, tag, tag, 1'b0);
        r.pc      = pc;
        r.rnd     = 1'b1;
        r.e_redir = 1'b1;
        r.e_ttgt  = TRAP_VECTOR;
        return r;
    endfunction

    task automatic add_row(row_t r);
        r.e_mcause = trap_mcause;
        r.e_mepc   = trap_mepc;
        rows.push_back(r);
    endtask

    task automatic build_table();
        row_t r;
        add_row(alu_row(3'd0, 3'd0, 1'b0, 32'h1234_5678));
        add_row(alu_row(3'd5, 3'd0, 1'b1, 32'h0));          // Stale tag
        add_row(load_row(LB,  2'd0, 32'hFFFF_FF93));
        add_row(load_row(LB,  2'd1, 32'h0000_007E));
        add_row(load_row(LB,  2'd2, 32'hFFFF_FF82));
        add_row(load_row(LB,  2'd3, 32'hFFFF_FFF1));
        add_row(load_row(LBU, 2'd0, 32'h0000_0093));
        add_row(load_row(LBU, 2'd1, 32'h0000_007E));
        add_row(load_row(LBU, 2'd2, 32'h0000_0082));
        add_row(load_row(LBU, 2'd3, 32'h0000_00F1));
        add_row(load_row(LH,  2'd0, 32'h0000_7E93));
        add_row(load_row(LH,  2'd2, 32'hFFFF_F182));
        add_row(load_row(LHU, 2'd0, 32'h0000_7E93));
        add_row(load_row(LHU, 2'd2, 32'h0000_F182));
        r = base_row(JAL, 3'd0, 3'd0, 1'b0);                // Taken jump with link
        r.pc     = 32'h0000_0040;
        r.we     = 1'b1;
        r.r0     = 32'h0000_0044;
        r.r1     = 32'h0000_0400;
        r.jmp    = 1'b1;
        r.e_we   = 1'b1;
        r.e_data = 32'h0000_0044;
        r.e_jmp  = 1'b1;
        r.e_jtgt = 32'h0000_0400;
        add_row(r);
        add_row(alu_row(3'd1, 3'd1, 1'b1, 32'h0));          // Slot behind the jump
        add_row(alu_row(3'd1, 3'd1, 1'b0, 32'hCAFE_0001));
        r = base_row(SW, 3'd1, 3'd1, 1'b0);
        r.be      = 4'hF;
        r.r0      = 32'hDEAD_BEEF;
        r.r1      = 32'h0000_2004;
        r.e_be    = 4'hF;
        r.e_addr  = 32'h0000_2004;
        r.e_mdata = 32'hDEAD_BEEF;
        add_row(r);
        r = base_row(SB, 3'd2, 3'd1, 1'b1);                 // Killed store
        r.be  = 4'b0010;
        r.r1  = 32'h0000_2005;
        r.rnd = 1'b1;
        add_row(r);
        r = exc_row(NOP, 3'd1, 32'h0000_0050);              // Illegal instruction
        r.instr     = 32'hFFFF_FFFF;
        r.exc       = 1'b1;
        trap_mcause = 32'd2;
        trap_mepc   = 32'h0000_0050;
        add_row(r);
        r = exc_row(ECALL, 3'd2, 32'h0000_0054);
        trap_mcause = 32'd11;
        trap_mepc   = 32'h0000_0054;
        add_row(r);
        r = exc_row(EBREAK, 3'd3, 32'h0000_0058);
        trap_mcause = 32'd3;
        trap_mepc   = 32'h0000_0058;
        add_row(r);
        r = alu_row(3'd4, 3'd4, 1'b0, 32'h0000_0777);       // Interrupt taken on an ADD
        r.pc        = 32'h0000_005C;
        r.irq       = 1'b1;
        r.e_redir   = 1'b1;
        r.e_ttgt    = TRAP_VECTOR;
        trap_mcause = 32'h8000_000B;
        trap_mepc   = 32'h0000_0060;
        add_row(r);
        r = exc_row(MRET, 3'd5, 32'h0000_0100);
        r.e_ttgt = 32'h0000_0060;                           // Back past the interrupted ADD
        add_row(r);
        add_row(alu_row(3'd6, 3'd6, 1'b0, 32'h0000_0042));
    endtask

    ////////////////////////////////////////////////////////////
    // Drive and check
    ////////////////////////////////////////////////////////////

    task automatic drive_row(row_t r);
        instruction_i       = r.instr;
        pc_i                = r.pc;
        result0_i           = r.rnd ? xlen_t'($urandom()) : r.r0;
        result1_i           = r.r1;
        tag_i               = r.tag;
        mem_write_enable_i  = r.be;
        write_enable_i      = r.we;
        jump_i              = r.jmp;
        operation_i         = r.op;
        exception_i         = r.exc;
        interrupt_pending_i = r.irq;
        mem_data_i          = LOAD_WORD;
    endtask

    task automatic compare_field(string name, logic [31:0] actual, logic [31:0] expected);
        assert (actual === expected) else begin
            $display("FAIL %0d ns %s expected %h actual %h", $time, name, expected, actual);
            $display("SIMULATION FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic check_outputs(row_t r);
        compare_field("killed_o", killed_o, r.e_kill);
        compare_field("current_tag_o", current_tag_o, r.e_tag);
        compare_field("regbank_write_enable_o", regbank_write_enable_o, r.e_we);
        if (r.e_we) begin
            compare_field("regbank_data_o", regbank_data_o, r.e_data);
        end
        compare_field("jump_o", jump_o, r.e_jmp);
        if (r.e_jmp) begin
            compare_field("jump_target_o", jump_target_o, r.e_jtgt);
        end
        compare_field("mem_write_enable_o", mem_write_enable_o, r.e_be);
        compare_field("mem_write_address_o", mem_write_address_o, r.e_addr);
        compare_field("mem_data_o", mem_data_o, r.e_mdata);
        compare_field("trap_redirect_o", trap_redirect_o, r.e_redir);
        if (r.e_redir) begin
            compare_field("trap_target_o", trap_target_o, r.e_ttgt);
        end
    endtask

    task automatic verify_trap_state(row_t r);
        compare_field("mcause_o", mcause_o, r.e_mcause);
        compare_field("mepc_o", mepc_o, r.e_mepc);
    endtask

    task automatic wait_reset_release();
        int cycles;
        cycles = 0;
        while (reset !== 1'b0) begin
            if (cycles == RESET_TIMEOUT) begin
                $display("Timeout: reset still asserted after %0d cycles", RESET_TIMEOUT);
                $display("SIMULATION FAILED");
                $fatal(1, "reset release timeout");
            end else begin
                @(posedge clk);
                cycles++;
            end
        end
    endtask

    initial begin
        void'($urandom(52156));
        clk         = 1'b0;
        trap_mcause = '0;
        trap_mepc   = MEPC_RESET;
        drive_row(base_row(NOP, 3'd0, 3'd0, 1'b0));      // Idle live NOP
        build_table();
        wait_reset_release();
        for (int i = 0; i < rows.size(); i++) begin
            @(posedge clk);
            #1;
            if (i > 0) begin
                verify_trap_state(rows[i-1]);           // Captured at this edge
            end
            drive_row(rows[i]);
            #3;
            check_outputs(rows[i]);
        end
        @(posedge clk);
        #1;
        verify_trap_state(rows[rows.size()-1]);
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

/* files.f */
retire_pkg.sv
priv_pkg.sv
commit_if.sv
load_aligner.sv
retire_stage.sv
trap_unit.sv
retire_top.sv
tb_retire_top.sv
